// ==== project.f ====
+incdir+design
design/commit_pkg.sv
design/flush_resolve.sv
design/fetch_redirect.sv
design/arch_rat.sv
design/commit_top.sv
testbench/commit_checker.sv
testbench/tb_commit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the commit control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_commit \
  -f project.f -o sim_commit

./obj_dir/sim_commit > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== testbench/tb_commit.sv ====
/* commit control testbench
   random commit traffic from an LCG into commit_top, compared by commit_checker */

`timescale 1ns/1ps

`include "commit_defs.svh"

module tb_commit;

  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 3000;
  localparam int CLK_PERIOD   = 4;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES + 200) * CLK_PERIOD;

  logic                                  clk;
  logic                                  rst_n;
  logic [`COMMIT_WIDTH-1:0]              cmt_valid_i;
  logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0] cmt_areg_i;
  commit_pkg::preg_t [`COMMIT_WIDTH-1:0] cmt_preg_i;
  logic [`ADDR_W-1:0]                    cmt_pc_i;
  logic                                  cmt_excp_i;
  commit_pkg::ecode_e                    cmt_ecode_i;
  logic [`ADDR_W-1:0]                    cmt_err_va_i;
  logic                                  cmt_br_redirect_i;
  logic [`ADDR_W-1:0]                    cmt_br_target_i;
  logic                                  cmt_ertn_i;
  logic                                  cmt_ibar_i;
  logic                                  cmt_priv_i;
  logic                                  cmt_icacop_i;
  logic                                  cmt_idle_i;
  logic [`ADDR_W-1:0]                    csr_eentry_i;
  logic [`ADDR_W-1:0]                    csr_tlbrentry_i;
  logic [`ADDR_W-1:0]                    csr_era_i;
  logic                                  csr_has_int_i;
  logic                                  icache_ready_i;
  logic [`AREG_W-1:0]                    rat_rd_areg_i;
  logic                                  flush_o;
  commit_pkg::flush_kind_e               flush_kind_o;
  logic [`ADDR_W-1:0]                    redirect_pc_o;
  logic                                  fetch_next_o;
  logic                                  excp_o;
  logic [`ADDR_W-1:0]                    era_o;
  commit_pkg::ecode_e                    ecode_o;
  logic                                  va_error_o;
  logic [`ADDR_W-1:0]                    bad_va_o;
  logic                                  excp_tlb_o;
  commit_pkg::preg_t                     rat_rd_preg_o;
  int                                    error_count_o;
  int                                    check_count_o;
  logic [31:0]                           lcg_state;

  commit_top dut (.*);

  commit_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic commit_pkg::ecode_e pick_ecode(input logic [3:0] sel);
    case (sel)
      4'd0:    return commit_pkg::INT;
      4'd1:    return commit_pkg::PIL;
      4'd2:    return commit_pkg::PIS;
      4'd3:    return commit_pkg::PIF;
      4'd4:    return commit_pkg::PME;
      4'd5:    return commit_pkg::PPI;
      4'd6:    return commit_pkg::ADE;
      4'd7:    return commit_pkg::ALE;
      4'd8:    return commit_pkg::SYS;
      4'd9:    return commit_pkg::BRK;
      4'd10:   return commit_pkg::TLBR;
      default: return commit_pkg::INE;
    endcase
  endfunction

  // ========================================================================
  // stimulus at the falling edge
  // ========================================================================

  task automatic drive_random_commit();
    logic [31:0] r;
    logic [31:0] f;
    logic [31:0] g;
    r = next_rand();
    f = next_rand();
    g = next_rand();
    cmt_valid_i[0]    = (r[31:28] != 4'd0);
    cmt_valid_i[1]    = (r[27:26] != 2'd0);
    cmt_ecode_i       = pick_ecode(f[31:28]);
    cmt_excp_i        = 1'b0;
    cmt_br_redirect_i = 1'b0;
    cmt_ertn_i        = 1'b0;
    cmt_ibar_i        = 1'b0;
    cmt_priv_i        = 1'b0;
    cmt_icacop_i      = 1'b0;
    cmt_idle_i        = 1'b0;
    // bias toward each flush kind
    // the last case mixes flags to hit the priority order
    case (r[25:23])
      3'd0: begin
        cmt_excp_i  = 1'b1;
        cmt_ecode_i = commit_pkg::TLBR;
      end
      3'd1: cmt_excp_i = 1'b1;
      3'd2: cmt_br_redirect_i = 1'b1;
      3'd3: cmt_ertn_i = 1'b1;
      3'd4: begin
        cmt_ibar_i   = (f[27:26] == 2'd0);
        cmt_priv_i   = (f[27:26] == 2'd1);
        cmt_icacop_i = (f[27:26] == 2'd2);
        cmt_idle_i   = (f[27:26] == 2'd3);
      end
      3'd5: cmt_excp_i = 1'b0;
      default: begin
        cmt_excp_i        = f[25];
        cmt_br_redirect_i = f[24];
        cmt_ertn_i        = f[23];
        cmt_ibar_i        = f[22];
        cmt_priv_i        = f[21];
        cmt_icacop_i      = f[20];
        cmt_idle_i        = f[19] & f[18] & f[17];
      end
    endcase
    cmt_pc_i        = next_rand();
    cmt_err_va_i    = next_rand();
    cmt_br_target_i = next_rand();
    // same arch register on both slots now and then
    cmt_areg_i[0]   = r[15:11];
    cmt_areg_i[1]   = r[21] ? r[15:11] : r[10:6];
    rat_rd_areg_i   = r[20:16];
    cmt_preg_i[0]   = g[31:26];
    cmt_preg_i[1]   = g[25:20];
    // rare interrupt so the idle lock holds for a while
    csr_has_int_i   = (g[19:14] == 6'd0);
    icache_ready_i  = (g[13:11] != 3'd0);
    if (g[10:8] == 3'd0) begin
      csr_eentry_i    = next_rand();
      csr_tlbrentry_i = next_rand();
      csr_era_i       = next_rand();
    end
  endtask

  initial begin
    lcg_state         = 32'd63959;
    rst_n             = 1'b0;
    cmt_valid_i       = '0;
    cmt_areg_i        = '0;
    cmt_preg_i        = '0;
    cmt_pc_i          = '0;
    cmt_excp_i        = 1'b0;
    cmt_ecode_i       = commit_pkg::INT;
    cmt_err_va_i      = '0;
    cmt_br_redirect_i = 1'b0;
    cmt_br_target_i   = '0;
    cmt_ertn_i        = 1'b0;
    cmt_ibar_i        = 1'b0;
    cmt_priv_i        = 1'b0;
    cmt_icacop_i      = 1'b0;
    cmt_idle_i        = 1'b0;
    csr_eentry_i      = 32'h1c00_8000;
    csr_tlbrentry_i   = 32'h1c00_f000;
    csr_era_i         = 32'h1c00_0100;
    csr_has_int_i     = 1'b0;
    icache_ready_i    = 1'b1;
    rat_rd_areg_i     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < TEST_CYCLES; n++) begin
      drive_random_commit();
      @(negedge clk);
    end
    // let the checker see the last registered outputs
    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", check_count_o, error_count_o);
    if (error_count_o == 0 && check_count_o > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the stimulus finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== testbench/commit_checker.sv ====
/* commit control checker
   models flush state, idle lock and alias table, compares every DUT output */

`timescale 1ns/1ps

`include "commit_defs.svh"

module commit_checker (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`COMMIT_WIDTH-1:0]              cmt_valid_i,
  input  logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0] cmt_areg_i,
  input  commit_pkg::preg_t [`COMMIT_WIDTH-1:0] cmt_preg_i,
  input  logic [`ADDR_W-1:0]                    cmt_pc_i,
  input  logic                                  cmt_excp_i,
  input  commit_pkg::ecode_e                    cmt_ecode_i,
  input  logic [`ADDR_W-1:0]                    cmt_err_va_i,
  input  logic                                  cmt_br_redirect_i,
  input  logic [`ADDR_W-1:0]                    cmt_br_target_i,
  input  logic                                  cmt_ertn_i,
  input  logic                                  cmt_ibar_i,
  input  logic                                  cmt_priv_i,
  input  logic                                  cmt_icacop_i,
  input  logic                                  cmt_idle_i,
  input  logic [`ADDR_W-1:0]                    csr_eentry_i,
  input  logic [`ADDR_W-1:0]                    csr_tlbrentry_i,
  input  logic [`ADDR_W-1:0]                    csr_era_i,
  input  logic                                  csr_has_int_i,
  input  logic                                  icache_ready_i,
  input  logic [`AREG_W-1:0]                    rat_rd_areg_i,
  input  logic                                  flush_o,
  input  commit_pkg::flush_kind_e               flush_kind_o,
  input  logic [`ADDR_W-1:0]                    redirect_pc_o,
  input  logic                                  fetch_next_o,
  input  logic                                  excp_o,
  input  logic [`ADDR_W-1:0]                    era_o,
  input  commit_pkg::ecode_e                    ecode_o,
  input  logic                                  va_error_o,
  input  logic [`ADDR_W-1:0]                    bad_va_o,
  input  logic                                  excp_tlb_o,
  input  commit_pkg::preg_t                     rat_rd_preg_o,
  output int                                    error_count_o,
  output int                                    check_count_o
);

  commit_pkg::flush_kind_e exp_kind;
  commit_pkg::ecode_e      exp_ecode;
  logic                    exp_excp;
  logic                    exp_va_error;
  logic                    exp_excp_tlb;
  logic                    exp_idle;
  logic                    lock;
  logic                    have_payload;
  logic [`ADDR_W-1:0]      exp_pc;
  logic [`ADDR_W-1:0]      exp_target;
  logic [`ADDR_W-1:0]      exp_era;
  logic [`ADDR_W-1:0]      exp_bad_va;
  commit_pkg::preg_t       table_q [`ARCH_REG_NUM];

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count_o++;
    if (got !== exp) begin
      error_count_o++;
      $display("Error %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // lowest priority first, later rules override
  function automatic commit_pkg::flush_kind_e expected_kind();
    commit_pkg::flush_kind_e k;
    k = commit_pkg::NONE;
    if (cmt_valid_i[0]) begin
      if (cmt_ibar_i || cmt_priv_i || cmt_icacop_i || cmt_idle_i) k = commit_pkg::REFETCH;
      if (cmt_ertn_i) k = commit_pkg::ERTN;
      if (cmt_br_redirect_i) k = commit_pkg::REDIRECT;
      if (cmt_excp_i) begin
        k = (cmt_ecode_i == commit_pkg::TLBR) ? commit_pkg::TLBREFILL : commit_pkg::EXCP;
      end
    end
    return k;
  endfunction

  function automatic logic va_code(input commit_pkg::ecode_e c);
    case (c)
      commit_pkg::ADE, commit_pkg::ALE, commit_pkg::TLBR, commit_pkg::PIF,
      commit_pkg::PPI, commit_pkg::PME, commit_pkg::PIS, commit_pkg::PIL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [`ADDR_W-1:0] expected_redirect();
    case (exp_kind)
      commit_pkg::TLBREFILL: return csr_tlbrentry_i;
      commit_pkg::EXCP:      return csr_eentry_i;
      commit_pkg::REDIRECT:  return exp_target;
      commit_pkg::ERTN:      return csr_era_i;
      commit_pkg::REFETCH:   return exp_pc + 32'd4;
      default:               return `RESET_PC;
    endcase
  endfunction

  // ========================================================================
  // compare against last cycle's model, then advance the model
  // ========================================================================

  task automatic compare_outputs();
    commit_pkg::preg_t exp_preg;
    exp_preg = (rat_rd_areg_i == '0) ? '0 : table_q[rat_rd_areg_i];
    check_value("flush_o", 32'(flush_o), 32'(exp_kind != commit_pkg::NONE));
    check_value("flush_kind_o", 32'(flush_kind_o), 32'(exp_kind));
    check_value("redirect_pc_o", redirect_pc_o, expected_redirect());
    check_value("fetch_next_o", 32'(fetch_next_o), 32'(icache_ready_i & ~lock));
    check_value("excp_o", 32'(excp_o), 32'(exp_excp));
    check_value("va_error_o", 32'(va_error_o), 32'(exp_va_error));
    check_value("excp_tlb_o", 32'(excp_tlb_o), 32'(exp_excp_tlb));
    if (have_payload) begin
      check_value("era_o", era_o, exp_era);
      check_value("ecode_o", 32'(ecode_o), 32'(exp_ecode));
      check_value("bad_va_o", bad_va_o, exp_bad_va);
    end
    check_value("rat_rd_preg_o", 32'(rat_rd_preg_o), 32'(exp_preg));
  endtask

  task automatic update_model();
    // interrupt beats a fresh idle commit
    if (csr_has_int_i) begin
      lock = 1'b0;
    end else if (exp_idle) begin
      lock = 1'b1;
    end
    exp_kind     = expected_kind();
    exp_idle     = cmt_valid_i[0] & cmt_idle_i;
    exp_excp     = cmt_valid_i[0] & cmt_excp_i;
    exp_va_error = exp_excp & va_code(cmt_ecode_i);
    exp_excp_tlb = exp_va_error & (cmt_ecode_i != commit_pkg::ADE)
                   & (cmt_ecode_i != commit_pkg::ALE);
    exp_pc       = cmt_pc_i;
    exp_target   = cmt_br_target_i;
    exp_ecode    = cmt_ecode_i;
    exp_bad_va   = cmt_err_va_i;
    exp_era      = cmt_pc_i;
    if (cmt_ecode_i == commit_pkg::SYS || cmt_ecode_i == commit_pkg::BRK) begin
      exp_era = cmt_pc_i + 32'd4;
    end
    have_payload = 1'b1;
    // slot 1 written last, so it wins
    for (int s = 0; s < `COMMIT_WIDTH; s++) begin
      if (cmt_valid_i[s] && cmt_areg_i[s] != '0) table_q[cmt_areg_i[s]] = cmt_preg_i[s];
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      error_count_o = 0;
      check_count_o = 0;
      exp_kind      = commit_pkg::NONE;
      exp_excp      = 1'b0;
      exp_va_error  = 1'b0;
      exp_excp_tlb  = 1'b0;
      exp_idle      = 1'b0;
      lock          = 1'b0;
      have_payload  = 1'b0;
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        table_q[i] = commit_pkg::preg_t'(i);
      end
    end else begin
      compare_outputs();
      update_model();
    end
  end

endmodule

// ==== design/commit_top.sv ====
/* commit control top
   flush resolve, fetch redirect and the architectural alias table */

`timescale 1ns/1ps

`include "commit_defs.svh"

module commit_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // commit slots
  input  logic [`COMMIT_WIDTH-1:0]               cmt_valid_i,
  input  logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]  cmt_areg_i,
  input  commit_pkg::preg_t [`COMMIT_WIDTH-1:0]  cmt_preg_i,
  // slot 0 only
  input  logic [`ADDR_W-1:0]                     cmt_pc_i,
  input  logic                                   cmt_excp_i,
  input  commit_pkg::ecode_e                     cmt_ecode_i,
  input  logic [`ADDR_W-1:0]                     cmt_err_va_i,
  input  logic                                   cmt_br_redirect_i,
  input  logic [`ADDR_W-1:0]                     cmt_br_target_i,
  input  logic                                   cmt_ertn_i,
  input  logic                                   cmt_ibar_i,
  input  logic                                   cmt_priv_i,
  input  logic                                   cmt_icacop_i,
  input  logic                                   cmt_idle_i,
  // CSR levels
  input  logic [`ADDR_W-1:0]                     csr_eentry_i,
  input  logic [`ADDR_W-1:0]                     csr_tlbrentry_i,
  input  logic [`ADDR_W-1:0]                     csr_era_i,
  input  logic                                   csr_has_int_i,
  input  logic                                   icache_ready_i,
  input  logic [`AREG_W-1:0]                     rat_rd_areg_i,
  // flush and fetch
  output logic                                   flush_o,
  output commit_pkg::flush_kind_e                flush_kind_o,
  output logic [`ADDR_W-1:0]                     redirect_pc_o,
  output logic                                   fetch_next_o,
  // exception report
  output logic                                   excp_o,
  output logic [`ADDR_W-1:0]                     era_o,
  output commit_pkg::ecode_e                     ecode_o,
  output logic                                   va_error_o,
  output logic [`ADDR_W-1:0]                     bad_va_o,
  output logic                                   excp_tlb_o,
  output commit_pkg::preg_t                      rat_rd_preg_o
);

  logic [`ADDR_W-1:0] flush_pc;
  logic [`ADDR_W-1:0] flush_target;
  logic               idle_cmt;

  // ========================================================================
  // flush resolve
  // ========================================================================

  flush_resolve u_flush_resolve (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmt_valid_i       (cmt_valid_i[0]),
    .cmt_pc_i          (cmt_pc_i),
    .cmt_excp_i        (cmt_excp_i),
    .cmt_ecode_i       (cmt_ecode_i),
    .cmt_err_va_i      (cmt_err_va_i),
    .cmt_br_redirect_i (cmt_br_redirect_i),
    .cmt_br_target_i   (cmt_br_target_i),
    .cmt_ertn_i        (cmt_ertn_i),
    .cmt_ibar_i        (cmt_ibar_i),
    .cmt_priv_i        (cmt_priv_i),
    .cmt_icacop_i      (cmt_icacop_i),
    .cmt_idle_i        (cmt_idle_i),
    .flush_o           (flush_o),
    .flush_kind_o      (flush_kind_o),
    .flush_pc_o        (flush_pc),
    .flush_target_o    (flush_target),
    .idle_cmt_o        (idle_cmt),
    .excp_o            (excp_o),
    .era_o             (era_o),
    .ecode_o           (ecode_o),
    .va_error_o        (va_error_o),
    .bad_va_o          (bad_va_o),
    .excp_tlb_o        (excp_tlb_o)
  );

  // ========================================================================
  // fetch redirect
  // ========================================================================

  fetch_redirect u_fetch_redirect (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_kind_i    (flush_kind_o),
    .flush_pc_i      (flush_pc),
    .flush_target_i  (flush_target),
    .csr_eentry_i    (csr_eentry_i),
    .csr_tlbrentry_i (csr_tlbrentry_i),
    .csr_era_i       (csr_era_i),
    .idle_cmt_i      (idle_cmt),
    .csr_has_int_i   (csr_has_int_i),
    .icache_ready_i  (icache_ready_i),
    .redirect_pc_o   (redirect_pc_o),
    .fetch_next_o    (fetch_next_o)
  );

  // ========================================================================
  // architectural alias table
  // ========================================================================

  arch_rat u_arch_rat (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmt_valid_i (cmt_valid_i),
    .cmt_areg_i  (cmt_areg_i),
    .cmt_preg_i  (cmt_preg_i),
    .rd_areg_i   (rat_rd_areg_i),
    .rd_preg_o   (rat_rd_preg_o)
  );

endmodule

// ==== design/arch_rat.sv ====
/* architectural alias table
   committed arch to physical register map with one combinational read */

`timescale 1ns/1ps

`include "commit_defs.svh"

module arch_rat (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`COMMIT_WIDTH-1:0]               cmt_valid_i,
  input  logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]  cmt_areg_i,
  input  commit_pkg::preg_t [`COMMIT_WIDTH-1:0]  cmt_preg_i,
  input  logic [`AREG_W-1:0]                     rd_areg_i,
  output commit_pkg::preg_t                      rd_preg_o
);

  commit_pkg::preg_t              rat_q [`ARCH_REG_NUM];
  logic [`COMMIT_WIDTH-1:0]       wr_en;

  // r0 is hardwired and never remapped
  always_comb begin
    for (int s = 0; s < `COMMIT_WIDTH; s++) begin
      wr_en[s] = cmt_valid_i[s] & (cmt_areg_i[s] != '0);
    end
  end

  // ========================================================================
  // commit write
  // ========================================================================

  // identity map out of reset
  // later slots overwrite earlier ones, so the youngest wins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        rat_q[i] <= commit_pkg::preg_t'(i);
      end
    end else begin
      for (int s = 0; s < `COMMIT_WIDTH; s++) begin
        if (wr_en[s]) begin
          rat_q[cmt_areg_i[s]] <= cmt_preg_i[s];
        end
      end
    end
  end

  // ========================================================================
  // read port
  // ========================================================================

  // entry 0 keeps its reset value so r0 reads preg 0
  assign rd_preg_o = rat_q[rd_areg_i];

endmodule

// ==== design/fetch_redirect.sv ====
/* fetch redirect
   picks the refetch address per flush kind and holds the idle lock */

`timescale 1ns/1ps

`include "commit_defs.svh"

module fetch_redirect (
  input  logic                    clk,
  input  logic                    rst_n,
  input  commit_pkg::flush_kind_e flush_kind_i,
  input  logic [`ADDR_W-1:0]      flush_pc_i,
  input  logic [`ADDR_W-1:0]      flush_target_i,
  input  logic [`ADDR_W-1:0]      csr_eentry_i,
  input  logic [`ADDR_W-1:0]      csr_tlbrentry_i,
  input  logic [`ADDR_W-1:0]      csr_era_i,
  input  logic                    idle_cmt_i,
  input  logic                    csr_has_int_i,
  input  logic                    icache_ready_i,
  output logic [`ADDR_W-1:0]      redirect_pc_o,
  output logic                    fetch_next_o
);

  logic idle_lock;

  // ========================================================================
  // target select
  // ========================================================================

  always_comb begin
    case (flush_kind_i)
      commit_pkg::TLBREFILL: begin
        redirect_pc_o = csr_tlbrentry_i;
      end
      commit_pkg::EXCP: begin
        redirect_pc_o = csr_eentry_i;
      end
      // mispredicted branch resumes at its resolved target
      commit_pkg::REDIRECT: begin
        redirect_pc_o = flush_target_i;
      end
      commit_pkg::ERTN: begin
        redirect_pc_o = csr_era_i;
      end
      commit_pkg::REFETCH: begin
        redirect_pc_o = flush_pc_i + `ADDR_W'(4);
      end
      default: begin
        redirect_pc_o = `RESET_PC;
      end
    endcase
  end

  // ========================================================================
  // idle lock
  // ========================================================================

  // a pending interrupt keeps the core from sleeping at all
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (idle_cmt_i && !csr_has_int_i) begin
      idle_lock <= 1'b1;
    end else if (csr_has_int_i) begin
      idle_lock <= 1'b0;
    end
  end

  // fetch advances only while the icache accepts and the core is awake
  assign fetch_next_o = icache_ready_i & ~idle_lock;

endmodule

// ==== design/flush_resolve.sv ====
/* flush resolve
   turns commit slot 0 into a registered flush kind and exception report */

`timescale 1ns/1ps

`include "commit_defs.svh"

module flush_resolve (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmt_valid_i,
  input  logic [`ADDR_W-1:0]   cmt_pc_i,
  input  logic                 cmt_excp_i,
  input  commit_pkg::ecode_e   cmt_ecode_i,
  input  logic [`ADDR_W-1:0]   cmt_err_va_i,
  input  logic                 cmt_br_redirect_i,
  input  logic [`ADDR_W-1:0]   cmt_br_target_i,
  input  logic                 cmt_ertn_i,
  input  logic                 cmt_ibar_i,
  input  logic                 cmt_priv_i,
  input  logic                 cmt_icacop_i,
  input  logic                 cmt_idle_i,
  output logic                 flush_o,
  output commit_pkg::flush_kind_e flush_kind_o,
  output logic [`ADDR_W-1:0]   flush_pc_o,
  output logic [`ADDR_W-1:0]   flush_target_o,
  output logic                 idle_cmt_o,
  output logic                 excp_o,
  output logic [`ADDR_W-1:0]   era_o,
  output commit_pkg::ecode_e   ecode_o,
  output logic                 va_error_o,
  output logic [`ADDR_W-1:0]   bad_va_o,
  output logic                 excp_tlb_o
);

  commit_pkg::flush_kind_e kind_d;
  logic                    excp_d;
  logic                    refetch_d;
  logic                    va_error_d;
  logic                    excp_tlb_d;
  logic [`ADDR_W-1:0]      era_d;

  // ========================================================================
  // slot 0 decode
  // ========================================================================

  assign excp_d    = cmt_valid_i & cmt_excp_i;
  assign refetch_d = cmt_ibar_i | cmt_priv_i | cmt_icacop_i | cmt_idle_i;

  always_comb begin
    kind_d = commit_pkg::NONE;
    if (cmt_valid_i) begin
      // refill first, since it also raises the generic exception
      if (cmt_excp_i && cmt_ecode_i == commit_pkg::TLBR) begin
        kind_d = commit_pkg::TLBREFILL;
      end else if (cmt_excp_i) begin
        kind_d = commit_pkg::EXCP;
      end else if (cmt_br_redirect_i) begin
        kind_d = commit_pkg::REDIRECT;
      end else if (cmt_ertn_i) begin
        kind_d = commit_pkg::ERTN;
      end else if (refetch_d) begin
        kind_d = commit_pkg::REFETCH;
      end
    end
  end

  // syscall and break return to the next instruction
  assign era_d = (cmt_ecode_i inside {commit_pkg::SYS, commit_pkg::BRK}) ?
                 cmt_pc_i + `ADDR_W'(4) : cmt_pc_i;

  // faults that load the bad virtual address
  assign va_error_d = excp_d & (cmt_ecode_i inside {
                        commit_pkg::ADE, commit_pkg::TLBR, commit_pkg::PIF,
                        commit_pkg::PPI, commit_pkg::ALE, commit_pkg::PME,
                        commit_pkg::PIS, commit_pkg::PIL});

  // translation faults only, address errors excluded
  assign excp_tlb_d = excp_d & (cmt_ecode_i inside {
                        commit_pkg::TLBR, commit_pkg::PIF, commit_pkg::PPI,
                        commit_pkg::PME, commit_pkg::PIS, commit_pkg::PIL});

  // ========================================================================
  // output registers
  // ========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_o      <= 1'b0;
      flush_kind_o <= commit_pkg::NONE;
      idle_cmt_o   <= 1'b0;
      excp_o       <= 1'b0;
      va_error_o   <= 1'b0;
      excp_tlb_o   <= 1'b0;
    end else begin
      flush_o      <= (kind_d != commit_pkg::NONE);
      flush_kind_o <= kind_d;
      idle_cmt_o   <= cmt_valid_i & cmt_idle_i;
      excp_o       <= excp_d;
      va_error_o   <= va_error_d;
      excp_tlb_o   <= excp_tlb_d;
    end
  end

  // report payload, qualified by the flags above
  always_ff @(posedge clk) begin
    flush_pc_o     <= cmt_pc_i;
    flush_target_o <= cmt_br_target_i;
    era_o          <= era_d;
    ecode_o        <= cmt_ecode_i;
    bad_va_o       <= cmt_err_va_i;
  end

endmodule

// ==== design/commit_pkg.sv ====
/* commit control types
   exception codes, flush kinds and the physical register index */

`include "commit_defs.svh"

package commit_pkg;

  // ========================================================================
  // exception codes as reported to the CSR file
  // ========================================================================

  typedef enum logic [`ECODE_W-1:0] {
    INT  = 6'h00,
    // page invalid on load, store, fetch
    PIL  = 6'h01,
    PIS  = 6'h02,
    PIF  = 6'h03,
    // page modify and privilege faults
    PME  = 6'h04,
    PPI  = 6'h07,
    // address errors
    ADE  = 6'h08,
    ALE  = 6'h09,
    // syscall and break resume past the trapping instruction
    SYS  = 6'h0B,
    BRK  = 6'h0C,
    INE  = 6'h0D,
    // TLB refill has its own entry point
    TLBR = 6'h3F
  } ecode_e;

  // ========================================================================
  // flush kinds, highest priority first after NONE
  // ========================================================================

  typedef enum logic [`FLUSH_KIND_W-1:0] {
    NONE,
    TLBREFILL,
    EXCP,
    REDIRECT,
    ERTN,
    // ibar, priv, icacop and idle all refetch from pc + 4
    REFETCH
  } flush_kind_e;

  // ========================================================================
  // rename indices
  // ========================================================================

  typedef logic [`PREG_W-1:0] preg_t;

endpackage

// ==== design/commit_defs.svh ====
/* commit control sizing macros
   slot count, register file sizes, address width and the boot vector */

`ifndef COMMIT_DEFS_SVH
`define COMMIT_DEFS_SVH

// ========================================================================
// commit bandwidth
// ========================================================================

// retired instructions per cycle, slot 0 is the oldest
`define COMMIT_WIDTH 2

// ========================================================================
// register files
// ========================================================================

`define ARCH_REG_NUM 32
`define PHY_REG_NUM 64

// index widths follow the table sizes
`define AREG_W $clog2(`ARCH_REG_NUM)
`define PREG_W $clog2(`PHY_REG_NUM)

// ========================================================================
// addresses and encodings
// ========================================================================

`define ADDR_W 32

// fetch address while no flush is pending
`define RESET_PC 32'h1c00_0000

`define ECODE_W 6
`define FLUSH_KIND_W 3

`endif
